// File: s16b_pkg.sv
// Fixed System 16B widths; bus_req_t.active must be one-hot, as the external mapper drives it
package s16b_pkg;

    // Mapper region lines, regions 0 to 2 hold program ROM
    localparam int reg_ram  = 3;
    localparam int reg_oram = 4;
    localparam int reg_vram = 5;
    localparam int reg_pal  = 6;
    localparam int reg_io   = 7;

    // Splits the VRAM region, set means character RAM
    localparam int char_sel_bit = 16;

    typedef logic [7:0] game_id_t;

    typedef enum logic [1:0] {
        pcb_5521,       // Also 5704
        pcb_5358_small,
        pcb_5358_large,
        pcb_5797
    } pcb_t;

    // One CPU bus cycle as seen after the mapper
    typedef struct packed {
        logic [23:1] addr;   // Word address
        logic        rnw;
        logic [1:0]  dsn;    // Active low, upper then lower
        logic [15:0] wdata;
        logic [7:0]  active; // One-hot region lines
    } bus_req_t;

    typedef struct packed {
        logic rom;
        logic ram;
        logic vram;
        logic chr;
        logic obj;
        logic pal;
        logic io;
    } cs_set_t;

    typedef struct packed {
        cs_set_t     cs;
        logic [17:0] rom_addr;  // Banked, word address
        logic        tbank_wr;
        logic        tbank_hi;  // Upper three bits of tile bank
        logic [2:0]  tbank_val;
        logic        rnw;
        logic [1:0]  dsn;
        logic [15:0] wdata;     // Carried along for the devices
    } dec_cycle_t;

    // Which device word goes back to the CPU
    typedef enum logic [2:0] {
        src_none,
        src_ram,
        src_rom,
        src_chr,
        src_pal,
        src_obj,
        src_io
    } src_t;

endpackage

// File: s16b_region_decode.sv
// One request per cycle in flight; Korean boards share the 5521 tile-bank rule
module s16b_region_decode import s16b_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       req_valid,
    input  bus_req_t   req,
    input  game_id_t   game_id,
    output logic       dec_valid,
    output dec_cycle_t dec
);

    pcb_t        pcb;
    logic        korean;
    logic [1:0]  act_enc;
    logic [17:0] bank_addr;
    cs_set_t     cs_next;
    logic        tbank_next;
    logic        any_ds;

    // Board family from the game id
    always_comb begin
        pcb    = pcb_5521;
        korean = 1'b0;
        casez (game_id[7:3])
            5'b001??: pcb = pcb_5797;
            5'b0001?: begin
                if (game_id == 8'h10 || game_id == 8'h15 || game_id == 8'h1a)
                    pcb = pcb_5358_large;
                else
                    pcb = pcb_5358_small;
            end
            5'b00001: korean = 1'b1;
            default:  pcb = pcb_5521;
        endcase
    end

    // ROM bank index from the three ROM regions
    always_comb begin
        case (req.active[2:0])
            3'b001:  act_enc = 2'd0;
            3'b010:  act_enc = 2'd1;
            3'b100:  act_enc = 2'd2;
            default: act_enc = 2'd0;
        endcase
    end

    always_comb begin
        if (korean)
            bank_addr = {1'b0, req.addr[17:1]};
        else begin
            case (pcb)
                pcb_5797:       bank_addr = req.addr[18:1];
                pcb_5358_large: bank_addr = {act_enc, req.addr[16:1]};
                pcb_5358_small: bank_addr = {1'b0, act_enc, req.addr[15:1]};
                default:        bank_addr = {act_enc[0], req.addr[17:1]}; // 512kB
            endcase
        end
    end

    assign any_ds = ~&req.dsn;

    always_comb begin
        cs_next.rom  = req.rnw && (pcb == pcb_5797 ? req.active[0] : |req.active[2:0]);
        cs_next.chr  = req.active[reg_vram] && req.addr[char_sel_bit];
        cs_next.vram = req.active[reg_vram] && !req.addr[char_sel_bit] && any_ds;
        cs_next.ram  = req.active[reg_ram] && any_ds;
        cs_next.obj  = req.active[reg_oram];
        cs_next.pal  = req.active[reg_pal];
        cs_next.io   = req.active[reg_io];
    end

    // 5797 keeps the tile bank in one sub-range of regions 1 and 2
    always_comb begin
        if (pcb == pcb_5797)
            tbank_next = (req.active[1] || req.active[2]) && req.addr[13:12] == 2'd2;
        else
            tbank_next = req.active[2];
        tbank_next = tbank_next && !req.rnw && !req.dsn[0];
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            dec_valid <= 1'b0;
        else
            dec_valid <= req_valid;
    end

    always_ff @(posedge clk) begin
        if (req_valid) begin
            dec.cs        <= cs_next;
            dec.rom_addr  <= bank_addr;
            dec.tbank_wr  <= tbank_next;
            dec.tbank_hi  <= req.addr[1];
            dec.tbank_val <= req.wdata[2:0];
            dec.rnw       <= req.rnw;
            dec.dsn       <= req.dsn;
            dec.wdata     <= req.wdata;
        end
    end

    // Back-to-back strobes would overwrite a cycle not yet taken by ctrl
    a_no_req_on_dec: assert property (@(posedge clk) disable iff (rst)
        req_valid |-> !dec_valid);

endmodule

// File: s16b_cycle_ctrl.sv
// Memory regions wait for rom_ok or ram_ok, with no timeout on a device that never answers
module s16b_cycle_ctrl import s16b_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        dec_valid,
    input  dec_cycle_t  dec,
    input  logic        rom_ok,
    input  logic        ram_ok,
    output cs_set_t     cs,
    output logic [17:0] rom_addr,
    output logic        done,
    output src_t        src,
    output logic [5:0]  tile_bank
);

    logic       busy;
    logic       load;
    src_t       src_next;
    logic       tbank_wr;
    logic       tbank_hi;
    logic [2:0] tbank_val;

    assign load = dec_valid && !busy;

    // Read source; writes never return a word
    always_comb begin
        src_next = src_none;
        if (dec.rnw) begin
            if (dec.cs.rom)                    src_next = src_rom;
            else if (dec.cs.ram || dec.cs.vram) src_next = src_ram;
            else if (dec.cs.chr)               src_next = src_chr;
            else if (dec.cs.pal)               src_next = src_pal;
            else if (dec.cs.obj)               src_next = src_obj;
            else if (dec.cs.io)                src_next = src_io;
        end
    end

    // Fast regions and unmapped cycles end right away
    always_comb begin
        if (cs.rom)
            done = busy && rom_ok;
        else if (cs.ram || cs.vram)
            done = busy && ram_ok;
        else
            done = busy;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= 1'b0;
            cs   <= '0;
        end else if (load) begin
            busy <= 1'b1;
            cs   <= dec.cs;
        end else if (done) begin
            busy <= 1'b0;
            cs   <= '0; // Select drops after the done cycle
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            rom_addr  <= dec.rom_addr;
            src       <= src_next;
            tbank_wr  <= dec.tbank_wr;
            tbank_hi  <= dec.tbank_hi;
            tbank_val <= dec.tbank_val;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            tile_bank <= '0;
        else if (done && tbank_wr) begin
            if (tbank_hi)
                tile_bank[5:3] <= tbank_val;
            else
                tile_bank[2:0] <= tbank_val;
        end
    end

    a_no_dec_busy: assert property (@(posedge clk) disable iff (rst)
        dec_valid |-> !busy);

    // Region lines are one-hot upstream, so selects must be too
    a_one_cs: assert property (@(posedge clk) disable iff (rst) $onehot0(cs));

endmodule

// File: s16b_read_mux.sv
// Device words must be valid in the done cycle; unmapped reads repeat the last word
module s16b_read_mux import s16b_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        done,
    input  src_t        src,
    input  logic [15:0] rom_data,
    input  logic [15:0] ram_data,  // RAM and VRAM share it
    input  logic [15:0] char_dout,
    input  logic [15:0] pal_dout,
    input  logic [15:0] obj_dout,
    input  logic [7:0]  cab_dout,
    output logic        rsp_valid,
    output logic [15:0] rsp_data
);

    logic [15:0] word;

    always_comb begin
        case (src)
            src_rom: word = rom_data;
            src_ram: word = ram_data;
            src_chr: word = char_dout;
            src_pal: word = pal_dout;
            src_obj: word = obj_dout;
            src_io:  word = {8'hff, cab_dout}; // Upper byte floats high
            default: word = rsp_data;          // No change
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rsp_valid <= 1'b0;
            rsp_data  <= '0;
        end else begin
            rsp_valid <= done;
            if (done)
                rsp_data <= word;
        end
    end

endmodule

// File: s16b_main_bus.sv
// No back-pressure, so the host waits for rsp_valid before the next req_valid
module s16b_main_bus import s16b_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        req_valid,
    input  bus_req_t    req,
    input  game_id_t    game_id,
    input  logic [15:0] rom_data,
    input  logic [15:0] ram_data,
    input  logic [15:0] char_dout,
    input  logic [15:0] pal_dout,
    input  logic [15:0] obj_dout,
    input  logic [7:0]  cab_dout,
    input  logic        rom_ok,
    input  logic        ram_ok,
    output cs_set_t     cs,
    output logic [17:0] rom_addr,
    output logic [15:0] wdata,
    output logic [1:0]  dsn,
    output logic [5:0]  tile_bank,
    output logic        rsp_valid,
    output logic [15:0] rsp_data
);

    logic       dec_valid;
    dec_cycle_t dec;
    logic       done;
    src_t       src;

    // Held in decode until the next request
    assign wdata = dec.wdata;
    assign dsn   = dec.dsn;

    s16b_region_decode u_decode (
        .clk       (clk),
        .rst       (rst),
        .req_valid (req_valid),
        .req       (req),
        .game_id   (game_id),
        .dec_valid (dec_valid),
        .dec       (dec)
    );

    s16b_cycle_ctrl u_ctrl (
        .clk       (clk),
        .rst       (rst),
        .dec_valid (dec_valid),
        .dec       (dec),
        .rom_ok    (rom_ok),
        .ram_ok    (ram_ok),
        .cs        (cs),
        .rom_addr  (rom_addr),
        .done      (done),
        .src       (src),
        .tile_bank (tile_bank)
    );

    s16b_read_mux u_mux (
        .clk       (clk),
        .rst       (rst),
        .done      (done),
        .src       (src),
        .rom_data  (rom_data),
        .ram_data  (ram_data),
        .char_dout (char_dout),
        .pal_dout  (pal_dout),
        .obj_dout  (obj_dout),
        .cab_dout  (cab_dout),
        .rsp_valid (rsp_valid),
        .rsp_data  (rsp_data)
    );

endmodule

// File: tb_s16b_main_bus.sv
// Devices answer from the held request address; ok delays are drawn with the stimulus from one seed
module tb_s16b_main_bus import s16b_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    typedef struct packed {
        cs_set_t     cs;
        logic [17:0] rom_addr;
        logic [15:0] rsp;
        logic [5:0]  tbank;
        logic [15:0] wdata;
        logic [1:0]  dsn;
        logic        fast;     // Fixed 3 cycle latency
    } exp_t;

    logic        clk = 1'b0;
    logic        rst;
    logic        req_valid;
    bus_req_t    req;
    game_id_t    game_id;
    logic [15:0] rom_data;
    logic [15:0] ram_data;
    logic [15:0] char_dout;
    logic [15:0] pal_dout;
    logic [15:0] obj_dout;
    logic [7:0]  cab_dout;
    logic        rom_ok = 1'b0;
    logic        ram_ok = 1'b0;
    cs_set_t     cs;
    logic [17:0] rom_addr;
    logic [15:0] wdata;
    logic [1:0]  dsn;
    logic [5:0]  tile_bank;
    logic        rsp_valid;
    logic [15:0] rsp_data;

    int          seed = 32'h158c;
    exp_t        want;
    logic [15:0] model_rsp;
    logic [5:0]  model_bank;
    logic        timed_out;
    int          ok_delay;
    int          ok_wait = 0;
    logic        ok_armed = 1'b0;
    int          cyc = 0;
    int          req_cyc = 0;
    logic        pending = 1'b0;
    cs_set_t     seen_cs = '0;
    int          errors = 0;
    int          responses = 0;
    game_id_t    families [5] = '{8'h40, 8'h10, 8'h11, 8'h20, 8'h08};

    s16b_main_bus dut (.*);

    always #5 clk = ~clk;

    // Distinct word per device so a wrong source shows up
    function automatic logic [15:0] dev_word(input int k, input logic [23:1] a);
        return a[16:1] ^ {4{k[3:0]}};
    endfunction

    assign rom_data  = dev_word(1, req.addr);
    assign ram_data  = dev_word(2, req.addr);
    assign char_dout = dev_word(3, req.addr);
    assign pal_dout  = dev_word(4, req.addr);
    assign obj_dout  = dev_word(5, req.addr);
    assign cab_dout  = req.addr[8:1];

    function automatic exp_t ref_cycle(input game_id_t gid, input bus_req_t r,
                                       input logic [15:0] prev, input logic [5:0] bank);
        exp_t       e;
        pcb_t       fam;
        logic       kor;
        logic [1:0] bk;
        logic       any_ds;
        logic       hit;
        kor = (gid[7:3] == 5'b00001);
        if (gid[7:5] == 3'b001)
            fam = pcb_5797;
        else if (gid[7:4] == 4'b0001)
            fam = (gid == 8'h10 || gid == 8'h15 || gid == 8'h1a) ? pcb_5358_large : pcb_5358_small;
        else
            fam = pcb_5521;
        bk = r.active[1] ? 2'd1 : (r.active[2] ? 2'd2 : 2'd0);
        if (kor)
            e.rom_addr = {1'b0, r.addr[17:1]};
        else if (fam == pcb_5797)
            e.rom_addr = r.addr[18:1];
        else if (fam == pcb_5358_large)
            e.rom_addr = {bk, r.addr[16:1]};
        else if (fam == pcb_5358_small)
            e.rom_addr = {1'b0, bk, r.addr[15:1]};
        else
            e.rom_addr = {bk[0], r.addr[17:1]};
        any_ds = (r.dsn != 2'b11);
        e.cs      = '0;
        e.cs.rom  = r.rnw && (fam == pcb_5797 ? r.active[0] : (r.active[2:0] != 3'b000));
        e.cs.chr  = r.active[reg_vram] && r.addr[char_sel_bit];
        e.cs.vram = r.active[reg_vram] && !r.addr[char_sel_bit] && any_ds;
        e.cs.ram  = r.active[reg_ram] && any_ds;
        e.cs.obj  = r.active[reg_oram];
        e.cs.pal  = r.active[reg_pal];
        e.cs.io   = r.active[reg_io];
        e.rsp = prev; // Writes and unmapped reads keep the last word
        if (r.rnw) begin
            if (e.cs.rom)
                e.rsp = dev_word(1, r.addr);
            else if (e.cs.ram || e.cs.vram)
                e.rsp = dev_word(2, r.addr);
            else if (e.cs.chr)
                e.rsp = dev_word(3, r.addr);
            else if (e.cs.pal)
                e.rsp = dev_word(4, r.addr);
            else if (e.cs.obj)
                e.rsp = dev_word(5, r.addr);
            else if (e.cs.io)
                e.rsp = {8'hff, r.addr[8:1]};
        end
        if (fam == pcb_5797)
            hit = (r.active[1] || r.active[2]) && r.addr[13:12] == 2'd2;
        else
            hit = r.active[2];
        hit = hit && !r.rnw && !r.dsn[0];
        e.tbank = bank;
        if (hit && r.addr[1])
            e.tbank[5:3] = r.wdata[2:0];
        else if (hit)
            e.tbank[2:0] = r.wdata[2:0];
        e.wdata = r.wdata; // Devices see the request's data and strobes
        e.dsn   = r.dsn;
        e.fast = !(e.cs.rom || e.cs.ram || e.cs.vram);
        return e;
    endfunction

    // Memory devices raise ok after the drawn number of select cycles
    always @(posedge clk) begin
        #1;
        if (!(cs.rom || cs.ram || cs.vram)) begin
            ok_armed = 1'b0;
            rom_ok   = 1'b0;
            ram_ok   = 1'b0;
        end else begin
            if (!ok_armed) begin
                ok_armed = 1'b1;
                ok_wait  = ok_delay;
            end
            if (ok_wait == 0) begin
                rom_ok = cs.rom;
                ram_ok = !cs.rom;
            end else
                ok_wait--;
        end
    end

    // Outputs are settled at the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            cyc++;
            if (req_valid) begin
                pending = 1'b1;
                req_cyc = cyc;
                seen_cs = '0;
            end
            seen_cs = seen_cs | cs;
            if (cs.rom && rom_addr != want.rom_addr) begin
                errors++;
                $display("[FAIL] %0t: rom_addr %h, expected %h", $time, rom_addr, want.rom_addr);
            end
            if (cs != '0 && (wdata != want.wdata || dsn != want.dsn)) begin
                errors++;
                $display("[FAIL] %0t: wdata %h dsn %b, expected %h %b", $time, wdata, dsn,
                         want.wdata, want.dsn);
            end
            if (rsp_valid && !pending) begin
                errors++;
                $display("Unexpected rsp_valid with no bus cycle in flight at %0t", $time);
            end else if (rsp_valid) begin
                pending = 1'b0;
                responses++;
                if (seen_cs != want.cs) begin
                    errors++;
                    $display("[FAIL] %0t: chip selects %b, expected %b", $time, seen_cs, want.cs);
                end
                if (rsp_data != want.rsp) begin
                    errors++;
                    $display("[FAIL] %0t: rsp_data %h, expected %h", $time, rsp_data, want.rsp);
                end
                if (tile_bank != want.tbank) begin
                    errors++;
                    $display("[FAIL] %0t: tile_bank %h, expected %h", $time, tile_bank,
                             want.tbank);
                end
                if (want.fast && cyc - req_cyc != 3) begin
                    errors++;
                    $display("[FAIL] %0t: latency %0d cycles, expected 3", $time, cyc - req_cyc);
                end
            end
        end
    end

    task automatic finish_run();
        $display("Responses %0d, errors %0d", responses, errors);
        if (errors == 0 && !timed_out)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    endtask

    // Called 1 ns after a rising edge; returns at the same point after the response
    task automatic run_cycle(input game_id_t gid, input logic [23:1] addr, input logic rnw,
                             input logic [1:0] ds, input logic [15:0] wd, input int region);
        bus_req_t    r;
        logic [31:0] rnd;
        int          n;
        logic        seen;
        r.addr   = addr;
        r.rnw    = rnw;
        r.dsn    = ds;
        r.wdata  = wd;
        r.active = '0;
        if (region < 8)
            r.active[region[2:0]] = 1'b1; // Region 8 stands for unmapped
        want       = ref_cycle(gid, r, model_rsp, model_bank);
        model_rsp  = want.rsp;
        model_bank = want.tbank;
        rnd        = $random(seed);
        ok_delay   = rnd % 6;
        game_id    = gid;
        req        = r;
        req_valid  = 1'b1;
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        n    = 0;
        seen = 1'b0;
        while (!seen && n < 40) begin
            @(negedge clk);
            seen = rsp_valid;
            n++;
        end
        if (!seen) begin
            $display("Timeout: no rsp_valid within 40 cycles at %0t", $time);
            timed_out = 1'b1;
            finish_run();
        end else begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic random_cycle(input game_id_t gid);
        logic [31:0] r0;
        logic [31:0] r1;
        r0 = $random(seed);
        r1 = $random(seed);
        run_cycle(gid, r0[22:0], r1[0], r1[2:1], r1[31:16], int'(r1[7:4] % 4'd9));
    endtask

    initial begin
        rst        = 1'b1;
        req_valid  = 1'b0;
        req        = '0;
        game_id    = '0;
        ok_delay   = 0;
        model_rsp  = '0;
        model_bank = '0;
        timed_out  = 1'b0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int g = 0; g < 5; g++) begin
            for (int n = 0; n < 40; n++)
                random_cycle(families[g]);
        end
        run_cycle(8'h20, 23'h001001, 1'b0, 2'b00, 16'h0005, 2); // Upper bits
        run_cycle(8'h20, 23'h001000, 1'b0, 2'b00, 16'h0003, 1); // Lower bits
        run_cycle(8'h20, 23'h000801, 1'b0, 2'b00, 16'h0007, 2); // Wrong sub-range
        run_cycle(8'h20, 23'h001001, 1'b0, 2'b01, 16'h0006, 2); // Lower strobe high
        run_cycle(8'h40, 23'h000001, 1'b0, 2'b10, 16'h0002, 2);
        run_cycle(8'h40, 23'h000000, 1'b0, 2'b00, 16'h0004, 1); // ROM write, no select
        run_cycle(8'h40, 23'h0000a5, 1'b1, 2'b00, 16'h0000, 7);
        run_cycle(8'h40, 23'h000123, 1'b1, 2'b00, 16'h0000, 8); // Repeats the I/O word
        repeat (5) @(negedge clk);
        finish_run();
    end

endmodule

// File: sim.f
s16b_pkg.sv
s16b_region_decode.sv
s16b_cycle_ctrl.sv
s16b_read_mux.sv
s16b_main_bus.sv
tb_s16b_main_bus.sv

// File: Makefile
SRCS = s16b_pkg.sv s16b_region_decode.sv s16b_cycle_ctrl.sv s16b_read_mux.sv \
       s16b_main_bus.sv tb_s16b_main_bus.sv

obj_dir/Vtb_s16b_main_bus: sim.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_s16b_main_bus -f sim.f

run: obj_dir/Vtb_s16b_main_bus
	./obj_dir/Vtb_s16b_main_bus > sim.log 2>&1; cat sim.log
	@if grep -qF '** FAIL **' sim.log || ! grep -qF '** PASS **' sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
